// File: src/rv_params.svh
// widths, phase numbers and opcode fields (inst[6:2]) for the rv64i subset only; XLEN must stay 64
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define XLEN          64
`define NREGS         32
`define ID_PHASE      4
`define WB_PHASE      5

`define OPCODE_LUI    5'b01101
`define OPCODE_AUIPC  5'b00101
`define OPCODE_JAL    5'b11011
`define OPCODE_JALR   5'b11001
`define OPCODE_BEQ    5'b11000
`define OPCODE_LB     5'b00000
`define OPCODE_SB     5'b01000
`define OPCODE_ADDI   5'b00100
`define OPCODE_ADD    5'b01100
`define OPCODE_FENCE  5'b00011
`define OPCODE_ENV    5'b11100
`define OPCODE_ADDIW  5'b00110
`define OPCODE_ADDW   5'b01110
`define FUNCT3_SLLI   3'b001
`define FUNCT3_SRLI   3'b101
`endif

// File: src/rv_pkg.sv
// stage-to-stage records for the multi-cycle slice; field widths assume XLEN of 64
`include "rv_params.svh"

package rv_pkg;

  // instruction format, picks the immediate layout
  typedef enum logic [2:0] {
    IT_R,
    IT_I,
    IT_U,
    IT_S,
    IT_B,
    IT_J,
    IT_NONE
  } itype_e;

  // decode result, captured by ex_stage at the end of phase 4
  typedef struct packed {
    logic [4:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [4:0]        rd;
    itype_e            itype;
    logic [`XLEN-1:0]  op1;
    logic [`XLEN-1:0]  op2;
    // branch target or jalr link
    logic [`XLEN-1:0]  t1;
    // pc of the instruction, for the fall-through pc
    logic [`XLEN-1:0]  pc;
    logic              is_load;
    logic              is_store;
    logic              wb_en;
  } id_out_t;

  // memory request, only live in phase 4
  typedef struct packed {
    logic              ren;
    logic              wen;
    logic [`XLEN-1:0]  addr;
    logic [`XLEN-1:0]  wdata;
  } mem_req_t;

  // writeback record, only live in phase 5
  typedef struct packed {
    logic              en;
    logic [4:0]        rd;
    logic [`XLEN-1:0]  data;
    logic [`XLEN-1:0]  next_pc;
    logic              taken;
  } wb_t;

endpackage

// File: src/inst_seq.sv
// one instruction in flight; inst_valid is dropped while busy, done pulses in phase 5
`include "rv_params.svh"

module inst_seq (
  input  logic              clk,
  input  logic              rst,
  input  logic              inst_valid,
  input  logic [31:0]       inst_in,
  input  logic [`XLEN-1:0]  pc_in,
  output logic [31:0]       inst,
  output logic [`XLEN-1:0]  pc,
  output logic [7:0]        phase,
  output logic              busy,
  output logic              done
);

  // phase counter where 0 means idle
  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= 8'd0;
    end else if (phase == 8'd0) begin
      if (inst_valid) begin
        phase <= 8'd1;
      end
    end else if (phase == 8'(`WB_PHASE)) begin
      phase <= 8'd0;
    end else begin
      phase <= phase + 8'd1;
    end
  end

  // instruction and pc held until the next accept
  always_ff @(posedge clk) begin
    if (phase == 8'd0 && inst_valid) begin
      inst <= inst_in;
      pc   <= pc_in;
    end
  end

  assign busy = (phase != 8'd0);
  assign done = (phase == 8'(`WB_PHASE));

  a_phase_range: assert property (@(posedge clk) disable iff (rst)
    phase <= 8'(`WB_PHASE));

  // an accepted strobe completes five cycles later
  a_done_after_accept: assert property (@(posedge clk) disable iff (rst)
    (phase == 8'd0 && inst_valid) |-> ##5 done);

endmodule

// File: src/regfile.sv
// 32 x 64-bit registers, reads are combinational, x0 is hardwired to zero
`include "rv_params.svh"

module regfile (
  input  logic              clk,
  input  logic              rst,
  input  logic [4:0]        rs1,
  input  logic [4:0]        rs2,
  output logic [`XLEN-1:0]  rs1_data,
  output logic [`XLEN-1:0]  rs2_data,
  input  rv_pkg::wb_t       wb
);

  logic [`XLEN-1:0] regs [`NREGS];

  // single write port, rd 0 dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  // writes aimed at x0 must leave it zero
  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    (wb.en && wb.rd == 5'd0) |=> (regs[0] == '0));

endmodule

// File: src/id_stage.sv
// decode for the rv64i subset; every output is zero outside phase 4, other opcodes decode as NONE
`include "rv_params.svh"

module id_stage (
  input  logic [31:0]       inst,
  input  logic [`XLEN-1:0]  pc,
  input  logic [7:0]        phase,
  input  logic [`XLEN-1:0]  rs1_data,
  input  logic [`XLEN-1:0]  rs2_data,
  output rv_pkg::id_out_t   id_out,
  output rv_pkg::mem_req_t  mem_req
);

  import rv_pkg::*;

  logic              id_active;
  logic [4:0]        opcode;
  logic [2:0]        funct3;
  logic              is_shift;
  itype_e            itype;
  logic [`XLEN-1:0]  imm;
  logic [`XLEN-1:0]  op1;
  logic [`XLEN-1:0]  op2;
  logic [`XLEN-1:0]  t1;
  logic              is_load;
  logic              is_store;
  logic              wb_en;

  assign id_active = (phase == 8'(`ID_PHASE));
  assign opcode    = inst[6:2];
  assign funct3    = inst[14:12];
  assign is_shift  = (opcode == `OPCODE_ADDI) &&
                     (funct3 == `FUNCT3_SLLI || funct3 == `FUNCT3_SRLI);

  always_comb begin
    case (opcode)
      `OPCODE_LUI, `OPCODE_AUIPC: itype = IT_U;
      `OPCODE_JAL:                itype = IT_J;
      `OPCODE_BEQ:                itype = IT_B;
      `OPCODE_SB:                 itype = IT_S;
      `OPCODE_ADD, `OPCODE_ADDW:  itype = IT_R;
      `OPCODE_JALR, `OPCODE_LB, `OPCODE_ADDI, `OPCODE_ADDIW,
      `OPCODE_FENCE, `OPCODE_ENV: itype = IT_I;
      default:                    itype = IT_NONE;
    endcase
  end

  // sign-extended immediate with shamt in its place for slli/srli
  always_comb begin
    if (is_shift) begin
      imm = {{(`XLEN-6){1'b0}}, inst[25:20]};
    end else begin
      case (itype)
        IT_I: imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
        IT_S: imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
        IT_B: imm = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        IT_U: imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
        IT_J: imm = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        default: imm = '0;
      endcase
    end
  end

  assign is_load  = (opcode == `OPCODE_LB);
  assign is_store = (opcode == `OPCODE_SB);
  assign wb_en    = (itype inside {IT_R, IT_I, IT_U, IT_J}) &&
                    (opcode != `OPCODE_FENCE) && (opcode != `OPCODE_ENV);

  always_comb begin
    op1 = '0;
    op2 = '0;
    case (itype)
      IT_R, IT_S, IT_B: begin
        op1 = rs1_data;
        op2 = rs2_data;
      end
      IT_I: begin
        op1 = rs1_data;
        op2 = imm;
      end
      IT_U: begin
        // lui passes imm through op1 and auipc adds pc in ex
        op1 = (opcode == `OPCODE_LUI) ? imm : pc;
        op2 = (opcode == `OPCODE_AUIPC) ? imm : '0;
      end
      IT_J: begin
        op1 = pc + 64'd4;
        op2 = pc + imm;
      end
      default: ;
    endcase
  end

  assign t1 = (opcode == `OPCODE_JALR) ? pc + 64'd4 :
              (opcode == `OPCODE_BEQ)  ? pc + imm   : '0;

  always_comb begin
    id_out  = '0;
    mem_req = '0;
    if (id_active) begin
      id_out.opcode   = opcode;
      id_out.funct3   = funct3;
      id_out.funct7   = inst[31:25];
      id_out.rd       = inst[11:7];
      id_out.itype    = itype;
      id_out.op1      = op1;
      id_out.op2      = op2;
      id_out.t1       = t1;
      id_out.pc       = pc;
      id_out.is_load  = is_load;
      id_out.is_store = is_store;
      id_out.wb_en    = wb_en;
      mem_req.ren     = is_load;
      mem_req.wen     = is_store;
      // address and data only shown for memory ops
      if (is_load || is_store) begin
        mem_req.addr = rs1_data + imm;
      end
      if (is_store) begin
        mem_req.wdata = rs2_data;
      end
    end
  end

endmodule

// File: src/ex_stage.sv
// execute and writeback for the decoded subset; wb is zero outside phase 5, srli is logical only
`include "rv_params.svh"

module ex_stage (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::id_out_t   id_out,
  input  logic [7:0]        phase,
  input  logic [7:0]        mem_rdata,
  output rv_pkg::wb_t       wb
);

  import rv_pkg::*;

  id_out_t           id_q;
  logic [`XLEN-1:0]  sum;
  logic [`XLEN-1:0]  sum_w;
  logic [`XLEN-1:0]  pc4;
  logic [`XLEN-1:0]  result;
  logic [`XLEN-1:0]  next_pc;
  logic              taken;

  // decode is silent after phase 4, keep a copy
  always_ff @(posedge clk) begin
    if (rst) begin
      id_q <= '0;
    end else if (phase == 8'(`ID_PHASE)) begin
      id_q <= id_out;
    end
  end

  assign sum   = id_q.op1 + id_q.op2;
  assign sum_w = {{(`XLEN-32){sum[31]}}, sum[31:0]};
  assign pc4   = id_q.pc + 64'd4;

  always_comb begin
    case (id_q.opcode)
      `OPCODE_ADD:   result = sum;
      `OPCODE_ADDI: begin
        case (id_q.funct3)
          `FUNCT3_SLLI: result = id_q.op1 << id_q.op2[5:0];
          `FUNCT3_SRLI: result = id_q.op1 >> id_q.op2[5:0];
          default:      result = sum;
        endcase
      end
      `OPCODE_ADDW, `OPCODE_ADDIW: result = sum_w;
      `OPCODE_LUI:   result = id_q.op1;
      `OPCODE_AUIPC: result = sum;
      // link is pc+4, in op1 for jal and t1 for jalr
      `OPCODE_JAL:   result = id_q.op1;
      `OPCODE_JALR:  result = id_q.t1;
      `OPCODE_LB:    result = {{(`XLEN-8){mem_rdata[7]}}, mem_rdata};
      default:       result = '0;
    endcase
  end

  always_comb begin
    next_pc = pc4;
    taken   = 1'b0;
    case (id_q.opcode)
      `OPCODE_JAL: begin
        next_pc = id_q.op2;
        taken   = 1'b1;
      end
      `OPCODE_JALR: begin
        next_pc = {sum[`XLEN-1:1], 1'b0};
        taken   = 1'b1;
      end
      `OPCODE_BEQ: begin
        if (id_q.op1 == id_q.op2) begin
          next_pc = id_q.t1;
          taken   = 1'b1;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    wb = '0;
    if (phase == 8'(`WB_PHASE)) begin
      wb.en      = id_q.wb_en;
      wb.rd      = id_q.wb_en ? id_q.rd : 5'd0;
      wb.data    = result;
      wb.next_pc = next_pc;
      wb.taken   = taken;
    end
  end

endmodule

// File: src/rv_slice_top.sv
// multi-cycle rv64i slice; caller supplies pc per instruction and serves memory through the ports
`include "rv_params.svh"

module rv_slice_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              inst_valid,
  input  logic [31:0]       inst,
  input  logic [`XLEN-1:0]  pc,
  input  logic [7:0]        mem_rdata,
  output logic              busy,
  output logic              done,
  output rv_pkg::mem_req_t  mem_req,
  output rv_pkg::wb_t       wb
);

  import rv_pkg::*;

  logic [31:0]       inst_q;
  logic [`XLEN-1:0]  pc_q;
  logic [7:0]        phase;
  logic [`XLEN-1:0]  rs1_data;
  logic [`XLEN-1:0]  rs2_data;
  id_out_t           id_out;

  inst_seq u_seq (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst_in    (inst),
    .pc_in      (pc),
    .inst       (inst_q),
    .pc         (pc_q),
    .phase      (phase),
    .busy       (busy),
    .done       (done)
  );

  // register indices come straight from the held word
  regfile u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1      (inst_q[19:15]),
    .rs2      (inst_q[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  id_stage u_id (
    .inst     (inst_q),
    .pc       (pc_q),
    .phase    (phase),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .id_out   (id_out),
    .mem_req  (mem_req)
  );

  ex_stage u_ex (
    .clk       (clk),
    .rst       (rst),
    .id_out    (id_out),
    .phase     (phase),
    .mem_rdata (mem_rdata),
    .wb        (wb)
  );

endmodule

// File: tests/tb_rv_slice.sv
// rows run in table order and share register state; expected values come from a model of x0..x31
`include "rv_params.svh"

module tb_rv_slice;

  import rv_pkg::*;

  localparam int CLK_PERIOD = 20;

  typedef struct {
    string       name;
    logic [31:0] inst;
    logic [63:0] pc;
    logic [7:0]  rdata;
    wb_t         exp_wb;
    mem_req_t    exp_mem;
  } row_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        inst_valid;
  logic [31:0] inst;
  logic [63:0] pc;
  logic [7:0]  mem_rdata;
  logic        busy;
  logic        done;
  mem_req_t    mem_req;
  wb_t         wb;

  row_t        rows[$];
  logic [63:0] model [32];
  logic [63:0] cur_pc;
  logic        table_ready = 1'b0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  rv_slice_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .mem_rdata  (mem_rdata),
    .busy       (busy),
    .done       (done),
    .mem_req    (mem_req),
    .wb         (wb)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [63:0] sext(logic [63:0] v, int bits);
    logic [63:0] sh;
    sh = v << (64 - bits);
    return 64'($signed(sh) >>> (64 - bits));
  endfunction

  // encoders take the 5-bit opcode field as op
  function automatic logic [31:0] enc_i(logic [4:0] op, logic [4:0] rd, logic [2:0] f3,
                                        logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op, 2'b11};
  endfunction

  function automatic logic [31:0] enc_r(logic [4:0] op, logic [4:0] rd, logic [4:0] rs1,
                                        logic [4:0] rs2);
    return {7'b0, rs2, rs1, 3'b000, rd, op, 2'b11};
  endfunction

  function automatic logic [31:0] enc_s(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], `OPCODE_SB, 2'b11};
  endfunction

  function automatic logic [31:0] enc_b(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], `OPCODE_BEQ, 2'b11};
  endfunction

  function automatic logic [31:0] enc_u(logic [4:0] op, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, op, 2'b11};
  endfunction

  function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPCODE_JAL, 2'b11};
  endfunction

  function automatic wb_t mk_wb(logic en, logic [4:0] rd, logic [63:0] data,
                                logic [63:0] npc, logic taken);
    wb_t w;
    w.en      = en;
    w.rd      = rd;
    w.data    = data;
    w.next_pc = npc;
    w.taken   = taken;
    return w;
  endfunction

  function automatic mem_req_t mk_mem(logic ren, logic wen, logic [63:0] addr,
                                      logic [63:0] wdata);
    mem_req_t m;
    m.ren   = ren;
    m.wen   = wen;
    m.addr  = addr;
    m.wdata = wdata;
    return m;
  endfunction

  function automatic string wb_text(wb_t w);
    return $sformatf("en=%0b rd=%0d data=%h next_pc=%h taken=%0b",
                     w.en, w.rd, w.data, w.next_pc, w.taken);
  endfunction

  function automatic string mem_text(mem_req_t m);
    return $sformatf("ren=%0b wen=%0b addr=%h wdata=%h", m.ren, m.wen, m.addr, m.wdata);
  endfunction

  // appends a row at cur_pc and moves the register model forward
  task automatic add_row(string name, logic [31:0] word, logic [7:0] rdata, wb_t w,
                         mem_req_t m);
    row_t r;
    r.name    = name;
    r.inst    = word;
    r.pc      = cur_pc;
    r.rdata   = rdata;
    r.exp_wb  = w;
    r.exp_mem = m;
    rows.push_back(r);
    if (w.en && w.rd != 5'd0) begin
      model[w.rd] = w.data;
    end
    cur_pc = cur_pc + 64'd4;
  endtask

  task automatic build_table();
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [63:0] v;
    logic [63:0] a;
    foreach (model[i]) model[i] = '0;
    cur_pc = 64'h8000_0000;
    imm_a  = 12'($urandom());
    imm_b  = 12'($urandom());
    v = sext(64'(imm_a), 12);
    add_row("addi_x1", enc_i(`OPCODE_ADDI, 5'd1, 3'b000, 5'd0, imm_a), 8'h00,
            mk_wb(1'b1, 5'd1, v, cur_pc + 4, 1'b0), '0);
    v = model[1] + sext(64'(imm_b), 12);
    add_row("addi_x2", enc_i(`OPCODE_ADDI, 5'd2, 3'b000, 5'd1, imm_b), 8'h00,
            mk_wb(1'b1, 5'd2, v, cur_pc + 4, 1'b0), '0);
    v = sext({32'h0, 20'h80001, 12'h000}, 32);
    add_row("lui_x3", enc_u(`OPCODE_LUI, 5'd3, 20'h80001), 8'h00,
            mk_wb(1'b1, 5'd3, v, cur_pc + 4, 1'b0), '0);
    v = sext({32'h0, 20'h80000, 12'h000}, 32);
    add_row("lui_x5", enc_u(`OPCODE_LUI, 5'd5, 20'h80000), 8'h00,
            mk_wb(1'b1, 5'd5, v, cur_pc + 4, 1'b0), '0);
    // 0x80000000 - 1 wraps to a positive word
    a = model[5] + sext(64'hfff, 12);
    add_row("addiw_ovf", enc_i(`OPCODE_ADDIW, 5'd6, 3'b000, 5'd5, 12'hfff), 8'h00,
            mk_wb(1'b1, 5'd6, sext(64'(a[31:0]), 32), cur_pc + 4, 1'b0), '0);
    a = model[6] + model[6];
    add_row("addw_ovf", enc_r(`OPCODE_ADDW, 5'd7, 5'd6, 5'd6), 8'h00,
            mk_wb(1'b1, 5'd7, sext(64'(a[31:0]), 32), cur_pc + 4, 1'b0), '0);
    add_row("add_x8", enc_r(`OPCODE_ADD, 5'd8, 5'd1, 5'd2), 8'h00,
            mk_wb(1'b1, 5'd8, model[1] + model[2], cur_pc + 4, 1'b0), '0);
    add_row("slli_x9", enc_i(`OPCODE_ADDI, 5'd9, `FUNCT3_SLLI, 5'd6, 12'd33), 8'h00,
            mk_wb(1'b1, 5'd9, model[6] << 33, cur_pc + 4, 1'b0), '0);
    add_row("srli_x10", enc_i(`OPCODE_ADDI, 5'd10, `FUNCT3_SRLI, 5'd3, 12'd4), 8'h00,
            mk_wb(1'b1, 5'd10, model[3] >> 4, cur_pc + 4, 1'b0), '0);
    add_row("addi_x0", enc_i(`OPCODE_ADDI, 5'd0, 3'b000, 5'd1, 12'd5), 8'h00,
            mk_wb(1'b1, 5'd0, model[1] + 64'd5, cur_pc + 4, 1'b0), '0);
    // x0 must still read zero here
    add_row("add_x0_x1", enc_r(`OPCODE_ADD, 5'd11, 5'd0, 5'd1), 8'h00,
            mk_wb(1'b1, 5'd11, model[1], cur_pc + 4, 1'b0), '0);
    v = cur_pc + sext({32'h0, 20'h12345, 12'h000}, 32);
    add_row("auipc_x12", enc_u(`OPCODE_AUIPC, 5'd12, 20'h12345), 8'h00,
            mk_wb(1'b1, 5'd12, v, cur_pc + 4, 1'b0), '0);
    add_row("jal_x13", enc_j(5'd13, 21'h100), 8'h00,
            mk_wb(1'b1, 5'd13, cur_pc + 4, cur_pc + 64'h100, 1'b1), '0);
    v = (model[12] + 64'd7) & ~64'd1;
    add_row("jalr_x14", enc_i(`OPCODE_JALR, 5'd14, 3'b000, 5'd12, 12'd7), 8'h00,
            mk_wb(1'b1, 5'd14, cur_pc + 4, v, 1'b1), '0);
    add_row("beq_taken", enc_b(5'd1, 5'd1, 13'h1ff0), 8'h00,
            mk_wb(1'b0, 5'd0, '0, cur_pc + sext(64'h1ff0, 13), 1'b1), '0);
    add_row("beq_not", enc_b(5'd1, 5'd12, 13'h1ff0), 8'h00,
            mk_wb(1'b0, 5'd0, '0, cur_pc + 4, 1'b0), '0);
    add_row("sb_x8", enc_s(5'd12, 5'd8, 12'hffd), 8'h00,
            mk_wb(1'b0, 5'd0, '0, cur_pc + 4, 1'b0),
            mk_mem(1'b0, 1'b1, model[12] + sext(64'hffd, 12), model[8]));
    add_row("lb_neg", enc_i(`OPCODE_LB, 5'd16, 3'b000, 5'd12, 12'h010), 8'h9c,
            mk_wb(1'b1, 5'd16, sext(64'h9c, 8), cur_pc + 4, 1'b0),
            mk_mem(1'b1, 1'b0, model[12] + 64'h10, '0));
    add_row("lb_pos", enc_i(`OPCODE_LB, 5'd17, 3'b000, 5'd12, 12'h7f0), 8'h5a,
            mk_wb(1'b1, 5'd17, 64'h5a, cur_pc + 4, 1'b0),
            mk_mem(1'b1, 1'b0, model[12] + 64'h7f0, '0));
    add_row("fence", enc_i(`OPCODE_FENCE, 5'd0, 3'b000, 5'd0, 12'h0ff), 8'h00,
            mk_wb(1'b0, 5'd0, '0, cur_pc + 4, 1'b0), '0);
  endtask

  task automatic note_failure(string msg);
    errors++;
    $display("error: %s", msg);
  endtask

  task automatic check_wb(string name, wb_t exp, wb_t act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s wb expected %s actual %s", name, wb_text(exp), wb_text(act));
    end
  endtask

  task automatic check_mem(string name, mem_req_t exp, mem_req_t act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s mem_req expected %s actual %s",
               name, mem_text(exp), mem_text(act));
    end
  endtask

  // starts just after a falling edge and returns in the first idle cycle
  task automatic run_row(row_t r);
    int cyc;
    int errors_before;
    errors_before = errors;
    inst_valid = 1'b1;
    inst       = r.inst;
    pc         = r.pc;
    mem_rdata  = r.rdata;
    cyc        = 0;
    while (!done && cyc < 10) begin
      @(negedge clk);
      cyc++;
      if (cyc == 1) begin
        if (!busy) note_failure({r.name, ": busy is low after the strobe"});
        // second strobe while busy must be dropped
        inst = enc_i(`OPCODE_ADDI, 5'd31, 3'b000, 5'd0, 12'd1);
        pc   = '1;
      end else begin
        inst_valid = 1'b0;
      end
      if (cyc == 4) begin
        check_mem(r.name, r.exp_mem, mem_req);
      end else if (mem_req !== '0) begin
        note_failure({r.name, ": mem_req is not zero outside the decode cycle"});
      end
    end
    if (!done) begin
      note_failure({r.name, ": done never arrived"});
    end else begin
      if (cyc != 5) note_failure({r.name, ": done did not come 5 cycles after the strobe"});
      check_wb(r.name, r.exp_wb, wb);
    end
    @(negedge clk);
    if (busy || done) note_failure({r.name, ": busy or done still high after writeback"});
    tests_run++;
    if (errors != errors_before) tests_failed++;
    $display("test %-12s %s", r.name, (errors == errors_before) ? "ok" : "failed");
  endtask

  initial begin
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    mem_rdata  = '0;
    void'($urandom(32'ha88e_aed5));
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    tests_run++;
    if (busy || done || mem_req.ren || mem_req.wen || wb.en) begin
      note_failure("busy, done or a strobe is not low after reset");
      tests_failed++;
      $display("test %-12s failed", "reset_state");
    end else begin
      $display("test %-12s ok", "reset_state");
    end
    foreach (rows[i]) run_row(rows[i]);
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // about 8 cycles per row plus reset and margin
  initial begin
    longint limit;
    wait (table_ready);
    limit = (rows.size() * 8 + 20) * CLK_PERIOD;
    #(limit);
    $display("watchdog expired before the last row finished");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: rv_slice.f
+incdir+src
src/rv_pkg.sv
src/inst_seq.sv
src/regfile.sv
src/id_stage.sv
src/ex_stage.sv
src/rv_slice_top.sv
tests/tb_rv_slice.sv

// File: Bender.yml
package:
  name: rv_slice

export_include_dirs:
  - src

sources:
  - files:
      - src/rv_pkg.sv
      - src/inst_seq.sv
      - src/regfile.sv
      - src/id_stage.sv
      - src/ex_stage.sv
      - src/rv_slice_top.sv
  - target: test
    files:
      - tests/tb_rv_slice.sv
